//--- hw/sat_pkg.sv
package sat_pkg;

    // clauses, variables and levels per bin
    localparam int NUM_SLOTS_DEF = 8;

    localparam int BIN_ID_W = 10;

    // every table is 512 deep
    localparam int ADDR_W = 9;

    localparam int VAR_STATE_W = 19;

    // {owning bin id, has-backtrack flag}
    localparam int LVL_STATE_W = 11;

    // level n sits at address n
    localparam int LVL_W = ADDR_W;

    // widest table word
    localparam int FILL_W = 19;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        SEEK,
        LEVELS,
        DRAIN,
        DONE
    } load_state_e;

    typedef enum logic [1:0] {
        T_CLAUSE,
        T_VAR,
        T_VSTATE,
        T_LSTATE
    } table_sel_e;

endpackage

//--- hw/bin_mem_if.sv
`timescale 1ns/1ps

interface bin_mem_if #(
    parameter int NUM_SLOTS = sat_pkg::NUM_SLOTS_DEF
);
    import sat_pkg::*;

    logic [ADDR_W-1:0]      clause_addr;
    logic [2*NUM_SLOTS-1:0] clause_data;
    logic [ADDR_W-1:0]      var_addr;
    logic [ADDR_W-1:0]      var_data;
    logic [ADDR_W-1:0]      vstate_addr;
    logic [VAR_STATE_W-1:0] vstate_data;
    logic [ADDR_W-1:0]      lstate_addr;
    logic [LVL_STATE_W-1:0] lstate_data;

    modport loader (
        output clause_addr, var_addr, vstate_addr, lstate_addr,
        input  clause_data, var_data, vstate_data, lstate_data
    );

    modport store (
        input  clause_addr, var_addr, vstate_addr, lstate_addr,
        output clause_data, var_data, vstate_data, lstate_data
    );

endinterface

//--- hw/bin_ram.sv
`timescale 1ns/1ps

module bin_ram #(
    parameter int DATA_W = 8,
    parameter int ADDR_W = 9
) (
    input  logic              clk,
    input  logic              we_i,
    input  logic [ADDR_W-1:0] waddr_i,
    input  logic [DATA_W-1:0] wdata_i,
    input  logic [ADDR_W-1:0] raddr_i,
    output logic [DATA_W-1:0] rdata_o
);

    logic [DATA_W-1:0] mem [2**ADDR_W];

    // fill port
    always_ff @(posedge clk)
    begin
        if (we_i)
        begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // data follows the address by one clock
    always_ff @(posedge clk)
    begin
        rdata_o <= mem[raddr_i];
    end

endmodule

//--- hw/bin_store.sv
`timescale 1ns/1ps

module bin_store #(
    parameter int NUM_SLOTS = sat_pkg::NUM_SLOTS_DEF
) (
    input  logic                       clk,
    input  logic                       fill_en_i,
    input  sat_pkg::table_sel_e        fill_sel_i,
    input  logic [sat_pkg::ADDR_W-1:0] fill_addr_i,
    input  logic [sat_pkg::FILL_W-1:0] fill_data_i,
    bin_mem_if.store                   mem
);
    import sat_pkg::*;

    localparam int CLAUSE_W = 2 * NUM_SLOTS;

    logic we_clause;
    logic we_var;
    logic we_vstate;
    logic we_lstate;

    // one table per fill cycle
    assign we_clause = fill_en_i && (fill_sel_i == T_CLAUSE);
    assign we_var    = fill_en_i && (fill_sel_i == T_VAR);
    assign we_vstate = fill_en_i && (fill_sel_i == T_VSTATE);
    assign we_lstate = fill_en_i && (fill_sel_i == T_LSTATE);

    bin_ram #(.DATA_W(CLAUSE_W), .ADDR_W(ADDR_W)) clause_ram_i (
        .clk(clk), .we_i(we_clause), .waddr_i(fill_addr_i),
        .wdata_i(fill_data_i[CLAUSE_W-1:0]),
        .raddr_i(mem.clause_addr), .rdata_o(mem.clause_data)
    );

    // variable ids are addresses into the state table
    bin_ram #(.DATA_W(ADDR_W), .ADDR_W(ADDR_W)) var_ram_i (
        .clk(clk), .we_i(we_var), .waddr_i(fill_addr_i),
        .wdata_i(fill_data_i[ADDR_W-1:0]),
        .raddr_i(mem.var_addr), .rdata_o(mem.var_data)
    );

    bin_ram #(.DATA_W(VAR_STATE_W), .ADDR_W(ADDR_W)) vstate_ram_i (
        .clk(clk), .we_i(we_vstate), .waddr_i(fill_addr_i),
        .wdata_i(fill_data_i[VAR_STATE_W-1:0]),
        .raddr_i(mem.vstate_addr), .rdata_o(mem.vstate_data)
    );

    bin_ram #(.DATA_W(LVL_STATE_W), .ADDR_W(ADDR_W)) lstate_ram_i (
        .clk(clk), .we_i(we_lstate), .waddr_i(fill_addr_i),
        .wdata_i(fill_data_i[LVL_STATE_W-1:0]),
        .raddr_i(mem.lstate_addr), .rdata_o(mem.lstate_data)
    );

endmodule

//--- hw/slot_scatter.sv
`timescale 1ns/1ps

module slot_scatter #(
    parameter int WIDTH     = 8,
    parameter int NUM_SLOTS = sat_pkg::NUM_SLOTS_DEF
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [NUM_SLOTS-1:0]         wr_i,
    input  logic [WIDTH-1:0]             data_i,
    output logic [WIDTH*NUM_SLOTS-1:0]   data_o
);

    // slot i lives at bits [i*WIDTH +: WIDTH]
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            data_o <= '0;
        end
        else
        begin
            for (int i = 0; i < NUM_SLOTS; i++)
            begin
                if (wr_i[i])
                begin
                    data_o[i*WIDTH +: WIDTH] <= data_i;
                end
            end
        end
    end

endmodule

//--- hw/load_bin.sv
`timescale 1ns/1ps

module load_bin #(
    parameter int NUM_SLOTS = sat_pkg::NUM_SLOTS_DEF
) (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       start_i,
    input  logic [sat_pkg::BIN_ID_W-1:0]               bin_id_i,
    input  logic [sat_pkg::LVL_W-1:0]                  cur_lvl_i,
    output logic                                       busy_o,
    output logic                                       done_o,
    output logic [sat_pkg::LVL_W-1:0]                  base_lvl_o,
    output logic                                       base_lvl_valid_o,
    output logic [2*NUM_SLOTS*NUM_SLOTS-1:0]           clauses_o,
    output logic [sat_pkg::VAR_STATE_W*NUM_SLOTS-1:0]  var_states_o,
    output logic [sat_pkg::LVL_STATE_W*NUM_SLOTS-1:0]  lvl_states_o,
    bin_mem_if.loader                                  mem
);
    import sat_pkg::*;

    localparam int CLAUSE_W = 2 * NUM_SLOTS;
    localparam int CNT_W    = $clog2(NUM_SLOTS) + 1;

    load_state_e            state;
    load_state_e            state_n;
    logic [CNT_W-1:0]       cnt;
    logic                   accept;
    logic [BIN_ID_W-1:0]    bin_q;
    logic [ADDR_W-1:0]      base_addr;
    logic [LVL_W-1:0]       seek_addr;
    logic [LVL_W-1:0]       chk_addr;
    logic                   chk_v;
    logic                   mismatch;
    logic                   seek_end;
    logic                   fetch_kick;
    logic                   fetch_d1;
    logic                   fetch_d2;
    logic                   lvl_kick;
    logic                   lvl_d1;
    logic [NUM_SLOTS-1:0]   wr_c;
    logic [NUM_SLOTS-1:0]   wr_v;
    logic [NUM_SLOTS-1:0]   wr_l;
    logic [CLAUSE_W-1:0]    clause_q;
    logic [VAR_STATE_W-1:0] vstate_q;
    logic [LVL_STATE_W-1:0] lstate_q;

    assign accept = (state == IDLE) && start_i;
    assign busy_o = (state != IDLE) && (state != DONE);
    assign done_o = (state == DONE);

    // entry one cycle behind its address, bin id in the upper bits
    assign mismatch = mem.lstate_data[LVL_STATE_W-1:1] != bin_q;
    assign seek_end = (state == SEEK) && chk_v && (mismatch || chk_addr == '0);

    always_comb
    begin
        state_n = state;
        case (state)
            IDLE:   if (start_i) state_n = FETCH;
            FETCH:  if (cnt == CNT_W'(NUM_SLOTS - 1)) state_n = SEEK;
            SEEK:   if (seek_end) state_n = LEVELS;
            LEVELS: if (cnt == CNT_W'(NUM_SLOTS - 1)) state_n = DRAIN;
            DRAIN:  if (cnt == CNT_W'(2)) state_n = DONE;
            default: state_n = IDLE;
        endcase
    end

    // counter restarts on every state change
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            state <= IDLE;
            cnt   <= '0;
        end
        else
        begin
            state <= state_n;
            cnt   <= (state_n != state) ? '0 : cnt + 1'b1;
        end
    end

    // request latch and downward level walk
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            bin_q     <= bin_id_i;
            base_addr <= ADDR_W'(bin_id_i * NUM_SLOTS);
            seek_addr <= cur_lvl_i;
        end
        else if (state == SEEK)
        begin
            seek_addr <= seek_addr - 1'b1;
        end
        chk_addr <= seek_addr;
        clause_q <= mem.clause_data;
        vstate_q <= mem.vstate_data;
        lstate_q <= mem.lstate_data;
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            chk_v            <= 1'b0;
            base_lvl_o       <= '0;
            base_lvl_valid_o <= 1'b0;
        end
        else
        begin
            chk_v <= (state == SEEK);
            if (accept)
            begin
                base_lvl_valid_o <= 1'b0;
            end
            else if (seek_end)
            begin
                // a break just above the last match, or the run reached level 0
                base_lvl_o       <= mismatch ? chk_addr + 1'b1 : '0;
                base_lvl_valid_o <= 1'b1;
            end
        end
    end

    assign mem.clause_addr = base_addr + ADDR_W'(cnt);
    assign mem.var_addr    = base_addr + ADDR_W'(cnt);
    assign mem.vstate_addr = mem.var_data;
    assign mem.lstate_addr = (state == LEVELS) ? base_lvl_o + LVL_W'(cnt) : seek_addr;

    assign fetch_kick = (state == FETCH) && (cnt == '0);
    assign lvl_kick   = (state == LEVELS) && (cnt == '0);

    // clause and level slots land 2 cycles after the address, var states 3
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            fetch_d1 <= 1'b0;
            fetch_d2 <= 1'b0;
            lvl_d1   <= 1'b0;
            wr_c     <= '0;
            wr_v     <= '0;
            wr_l     <= '0;
        end
        else
        begin
            fetch_d1 <= fetch_kick;
            fetch_d2 <= fetch_d1;
            lvl_d1   <= lvl_kick;
            wr_c     <= {wr_c[NUM_SLOTS-2:0], fetch_d1};
            wr_v     <= {wr_v[NUM_SLOTS-2:0], fetch_d2};
            wr_l     <= {wr_l[NUM_SLOTS-2:0], lvl_d1};
        end
    end

    slot_scatter #(.WIDTH(CLAUSE_W), .NUM_SLOTS(NUM_SLOTS)) clause_slots_i (
        .clk(clk), .rst(rst), .wr_i(wr_c), .data_i(clause_q), .data_o(clauses_o)
    );

    slot_scatter #(.WIDTH(VAR_STATE_W), .NUM_SLOTS(NUM_SLOTS)) vstate_slots_i (
        .clk(clk), .rst(rst), .wr_i(wr_v), .data_i(vstate_q), .data_o(var_states_o)
    );

    slot_scatter #(.WIDTH(LVL_STATE_W), .NUM_SLOTS(NUM_SLOTS)) lstate_slots_i (
        .clk(clk), .rst(rst), .wr_i(wr_l), .data_i(lstate_q), .data_o(lvl_states_o)
    );

endmodule

//--- hw/bin_load_top.sv
`timescale 1ns/1ps

module bin_load_top #(
    parameter int NUM_SLOTS = sat_pkg::NUM_SLOTS_DEF
) (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       start_i,
    input  logic [sat_pkg::BIN_ID_W-1:0]               bin_id_i,
    input  logic [sat_pkg::LVL_W-1:0]                  cur_lvl_i,
    input  logic                                       fill_en_i,
    input  sat_pkg::table_sel_e                        fill_sel_i,
    input  logic [sat_pkg::ADDR_W-1:0]                 fill_addr_i,
    input  logic [sat_pkg::FILL_W-1:0]                 fill_data_i,
    output logic                                       busy_o,
    output logic                                       done_o,
    output logic [sat_pkg::LVL_W-1:0]                  base_lvl_o,
    output logic                                       base_lvl_valid_o,
    output logic [2*NUM_SLOTS*NUM_SLOTS-1:0]           clauses_o,
    output logic [sat_pkg::VAR_STATE_W*NUM_SLOTS-1:0]  var_states_o,
    output logic [sat_pkg::LVL_STATE_W*NUM_SLOTS-1:0]  lvl_states_o
);

    bin_mem_if #(.NUM_SLOTS(NUM_SLOTS)) mem_if ();

    // tables, filled only while the loader is idle
    bin_store #(.NUM_SLOTS(NUM_SLOTS)) store_i (
        .clk         (clk),
        .fill_en_i   (fill_en_i),
        .fill_sel_i  (fill_sel_i),
        .fill_addr_i (fill_addr_i),
        .fill_data_i (fill_data_i),
        .mem         (mem_if.store)
    );

    load_bin #(.NUM_SLOTS(NUM_SLOTS)) loader_i (
        .clk              (clk),
        .rst              (rst),
        .start_i          (start_i),
        .bin_id_i         (bin_id_i),
        .cur_lvl_i        (cur_lvl_i),
        .busy_o           (busy_o),
        .done_o           (done_o),
        .base_lvl_o       (base_lvl_o),
        .base_lvl_valid_o (base_lvl_valid_o),
        .clauses_o        (clauses_o),
        .var_states_o     (var_states_o),
        .lvl_states_o     (lvl_states_o),
        .mem              (mem_if.loader)
    );

endmodule

//--- test/bin_ref_model.svh
`ifndef BIN_REF_MODEL_SVH
`define BIN_REF_MODEL_SVH

// images of the four tables, kept in step with the fill writes
logic [CLAUSE_W-1:0]    clause_img [TBL_DEPTH];
logic [ADDR_W-1:0]      var_img    [TBL_DEPTH];
logic [VAR_STATE_W-1:0] vstate_img [TBL_DEPTH];
logic [LVL_STATE_W-1:0] lstate_img [TBL_DEPTH];

// row k of a bin sits at bin * NUM_SLOTS + k
function automatic int unsigned bin_row(int unsigned bin_id, int unsigned k);
    return (bin_id * NUM_SLOTS + k) % TBL_DEPTH;
endfunction

function automatic logic [CLAUSE_W-1:0] exp_clause(int unsigned bin_id, int unsigned k);
    return clause_img[bin_row(bin_id, k)];
endfunction

// state of the variable named by the id table
function automatic logic [VAR_STATE_W-1:0] exp_vstate(int unsigned bin_id, int unsigned k);
    return vstate_img[var_img[bin_row(bin_id, k)]];
endfunction

function automatic logic [LVL_STATE_W-1:0] exp_lstate(int unsigned base, int unsigned k);
    return lstate_img[(base + k) % TBL_DEPTH];
endfunction

// walk down from cur while the owner matches, base is one above the break
function automatic int unsigned seek_base(int unsigned bin_id, int unsigned cur);
    int lvl;
    lvl = int'(cur);
    while (lvl >= 0)
    begin
        if (lstate_img[lvl][LVL_STATE_W-1:1] != BIN_ID_W'(bin_id))
        begin
            break;
        end
        lvl--;
    end
    return (lvl + 1) % TBL_DEPTH;
endfunction

`endif

//--- test/bin_load_tb.sv
`timescale 1ns/1ps

module bin_load_tb;
    import sat_pkg::*;

    localparam int NUM_SLOTS   = NUM_SLOTS_DEF;
    localparam int CLAUSE_W    = 2 * NUM_SLOTS;
    localparam int TBL_DEPTH   = 2 ** ADDR_W;
    localparam int CLK_PERIOD  = 20;
    localparam int LOAD_CYCLES = 4 * NUM_SLOTS + 520;
    // owner of every level outside the chosen runs
    localparam logic [BIN_ID_W-1:0] FREE_BIN = '1;

    logic                            clk;
    logic                            rst;
    logic                            start_i;
    logic [BIN_ID_W-1:0]             bin_id_i;
    logic [LVL_W-1:0]                cur_lvl_i;
    logic                            fill_en_i;
    table_sel_e                      fill_sel_i;
    logic [ADDR_W-1:0]               fill_addr_i;
    logic [FILL_W-1:0]               fill_data_i;
    logic                            busy_o;
    logic                            done_o;
    logic [LVL_W-1:0]                base_lvl_o;
    logic                            base_lvl_valid_o;
    logic [CLAUSE_W*NUM_SLOTS-1:0]   clauses_o;
    logic [VAR_STATE_W*NUM_SLOTS-1:0] var_states_o;
    logic [LVL_STATE_W*NUM_SLOTS-1:0] lvl_states_o;

    int    errors;
    int    checks;
    int    tests;
    int    errors_at_start;
    string test_name;

    `include "bin_ref_model.svh"

    bin_load_top #(.NUM_SLOTS(NUM_SLOTS)) dut_i (
        .clk(clk), .rst(rst), .start_i(start_i), .bin_id_i(bin_id_i),
        .cur_lvl_i(cur_lvl_i), .fill_en_i(fill_en_i), .fill_sel_i(fill_sel_i),
        .fill_addr_i(fill_addr_i), .fill_data_i(fill_data_i), .busy_o(busy_o),
        .done_o(done_o), .base_lvl_o(base_lvl_o), .base_lvl_valid_o(base_lvl_valid_o),
        .clauses_o(clauses_o), .var_states_o(var_states_o), .lvl_states_o(lvl_states_o)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // handshake rules, checked on every edge out of reset
    done_pulse: assert property (@(posedge clk) disable iff (!rst) done_o |=> !done_o)
    else
    begin
        $display("done_o stayed high for more than one cycle");
        errors = errors + 1;
    end

    busy_after_start: assert property (@(posedge clk) disable iff (!rst)
        (start_i && !busy_o && !done_o) |=> busy_o)
    else
    begin
        $display("busy_o did not rise the cycle after an idle start");
        errors = errors + 1;
    end

    busy_until_done: assert property (@(posedge clk) disable iff (!rst)
        $fell(busy_o) |-> done_o)
    else
    begin
        $display("busy_o fell without done_o");
        errors = errors + 1;
    end

    busy_needs_start: assert property (@(posedge clk) disable iff (!rst)
        $rose(busy_o) |-> $past(start_i))
    else
    begin
        $display("busy_o rose without a start pulse");
        errors = errors + 1;
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic check_value(input string what, input logic [63:0] exp,
                               input logic [63:0] act);
        checks++;
        assert (act === exp)
        else
        begin
            $display("ERROR %s, %s: expected %0h, actual %0h", test_name, what, exp, act);
            errors = errors + 1;
        end
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        int n;
        n = errors - errors_at_start;
        tests++;
        if (n == 0)
        begin
            $display("test %s: ok", test_name);
        end
        else
        begin
            $display("test %s: %0d errors", test_name, n);
        end
    endtask

    task automatic write_word(input table_sel_e sel, input int unsigned addr,
                              input logic [FILL_W-1:0] data);
        fill_en_i   = 1'b1;
        fill_sel_i  = sel;
        fill_addr_i = ADDR_W'(addr);
        fill_data_i = data;
        next_cycle();
    endtask

    // give levels lo..hi to one bin, flag bit random
    task automatic claim_levels(input int unsigned bin_id, input int lo, input int hi);
        for (int l = lo; l <= hi; l++)
        begin
            lstate_img[l] = {BIN_ID_W'(bin_id), 1'($urandom())};
        end
    endtask

    task automatic build_images();
        for (int a = 0; a < TBL_DEPTH; a++)
        begin
            clause_img[a] = CLAUSE_W'($urandom());
            var_img[a]    = ADDR_W'($urandom() % TBL_DEPTH);
            vstate_img[a] = VAR_STATE_W'($urandom());
            lstate_img[a] = {FREE_BIN, 1'($urandom())};
        end
        claim_levels(5, 100, 106);
        claim_levels(9, 0, 3);
        claim_levels(12, 201, 204);
        claim_levels(7, 150, 152);
        claim_levels(20, 296, 300);
        claim_levels(40, 507, 511);
    endtask

    task automatic write_tables();
        for (int a = 0; a < TBL_DEPTH; a++)
        begin
            write_word(T_CLAUSE, a, FILL_W'(clause_img[a]));
            write_word(T_VAR, a, FILL_W'(var_img[a]));
            write_word(T_VSTATE, a, FILL_W'(vstate_img[a]));
            write_word(T_LSTATE, a, FILL_W'(lstate_img[a]));
        end
        fill_en_i = 1'b0;
        next_cycle();
    endtask

    // poke sends a second start while the load is busy
    task automatic run_load(input int unsigned bin_id, input int unsigned cur, input bit poke);
        int waited;
        next_cycle();
        bin_id_i  = BIN_ID_W'(bin_id);
        cur_lvl_i = LVL_W'(cur);
        start_i   = 1'b1;
        next_cycle();
        start_i = 1'b0;
        check_value("busy_o after start", 1, busy_o);
        // the previous base is withdrawn by the new request
        check_value("base_lvl_valid_o after start", 0, base_lvl_valid_o);
        if (poke)
        begin
            repeat (3) next_cycle();
            bin_id_i  = 63;
            cur_lvl_i = '0;
            start_i   = 1'b1;
            next_cycle();
            start_i = 1'b0;
        end
        waited = 0;
        while (!done_o && waited < LOAD_CYCLES)
        begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!done_o)
        begin
            $display("load of bin %0d never raised done_o", bin_id);
            errors = errors + 1;
        end
    endtask

    task automatic check_load(input int unsigned bin_id, input int unsigned cur);
        int unsigned base;
        base = seek_base(bin_id, cur);
        check_value("base_lvl_o", base, base_lvl_o);
        check_value("base_lvl_valid_o", 1, base_lvl_valid_o);
        check_value("busy_o at done", 0, busy_o);
        for (int k = 0; k < NUM_SLOTS; k++)
        begin
            check_value($sformatf("clause slot %0d", k), exp_clause(bin_id, k),
                        clauses_o[k*CLAUSE_W +: CLAUSE_W]);
            check_value($sformatf("var state slot %0d", k), exp_vstate(bin_id, k),
                        var_states_o[k*VAR_STATE_W +: VAR_STATE_W]);
            check_value($sformatf("level slot %0d", k), exp_lstate(base, k),
                        lvl_states_o[k*LVL_STATE_W +: LVL_STATE_W]);
        end
    endtask

    task automatic check_cleared();
        check_value("busy_o", 0, busy_o);
        check_value("done_o", 0, done_o);
        check_value("base_lvl_valid_o", 0, base_lvl_valid_o);
        for (int k = 0; k < NUM_SLOTS; k++)
        begin
            check_value($sformatf("clause slot %0d", k), 0, clauses_o[k*CLAUSE_W +: CLAUSE_W]);
            check_value($sformatf("var state slot %0d", k), 0,
                        var_states_o[k*VAR_STATE_W +: VAR_STATE_W]);
            check_value($sformatf("level slot %0d", k), 0,
                        lvl_states_o[k*LVL_STATE_W +: LVL_STATE_W]);
        end
    endtask

    initial
    begin
        errors      = 0;
        checks      = 0;
        tests       = 0;
        rst         = 1'b0;
        start_i     = 1'b0;
        bin_id_i    = '0;
        cur_lvl_i   = '0;
        fill_en_i   = 1'b0;
        fill_sel_i  = T_CLAUSE;
        fill_addr_i = '0;
        fill_data_i = '0;
        void'($urandom(32'h26b5_b37d));
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b1;

        begin_test("reset");
        next_cycle();
        check_cleared();
        end_test();

        build_images();
        write_tables();

        begin_test("run_ends_at_cur");
        run_load(5, 106, 1'b0);
        check_load(5, 106);
        end_test();

        begin_test("run_reaches_level0");
        run_load(9, 3, 1'b0);
        check_load(9, 3);
        end_test();

        begin_test("miss_at_cur");
        run_load(12, 200, 1'b0);
        check_load(12, 200);
        end_test();

        begin_test("start_while_busy");
        run_load(7, 152, 1'b1);
        check_load(7, 152);
        end_test();

        // second start lands in the idle cycle right after done
        begin_test("back_to_back");
        run_load(20, 300, 1'b0);
        check_load(20, 300);
        run_load(40, 511, 1'b0);
        check_load(40, 511);
        end_test();

        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0)
        begin
            $display("All checks passed");
        end
        else
        begin
            $display("Checks failed");
        end
        $finish;
    end

    // six loads worth of cycles, fill included
    initial
    begin
        #(6 * LOAD_CYCLES * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("Checks failed");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+test
hw/sat_pkg.sv
hw/bin_mem_if.sv
hw/bin_ram.sv
hw/bin_store.sv
hw/slot_scatter.sv
hw/load_bin.sv
hw/bin_load_top.sv
test/bin_load_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the bin loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f filelist.f --top-module bin_load_tb \
    -o bin_load_sim \
    && ./obj_dir/bin_load_sim | tee /dev/stderr | grep -q "All checks passed" \
    && echo "simulation ok" \
    || { echo "simulation reported errors or did not build"; exit 1; }
